/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [31:0]  a,
    input  logic [31:0]  b,
    input  rvPkg::aluOpT aluOp,
    output logic [31:0]  result,
    output logic         zero,
    output logic         less
);
    import rvPkg::*;

    logic [4:0] shamt;

    // only the low five bits shift
    assign shamt = b[4:0];

    always_comb begin
        case (aluOp)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_SLL:   result = a << shamt;
            ALU_SLT:   result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:  result = {31'd0, a < b};
            ALU_XOR:   result = a ^ b;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = $unsigned($signed(a) >>> shamt);
            ALU_OR:    result = a | b;
            ALU_AND:   result = a & b;
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

    // flags used by branch resolution
    assign zero = (result == 32'd0);
    assign less = result[0];

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  logic [6:0]     opcode,
    input  logic [2:0]     funct3,
    input  logic           funct7b5,
    input  logic           zero,
    input  logic           less,
    output rvPkg::immTypeT immType,
    output rvPkg::aluOpT   aluOp,
    output rvPkg::bSrcT    bSrc,
    output logic           aSrcPc,
    output logic           regWrite,
    output logic           memRead,
    output logic           memWrite,
    output logic           pcBaseRs1,
    output logic           pcTaken,
    output logic           isHalt
);
    import rvPkg::*;

    opcodeT opc;
    aluOpT  funcOp;
    logic   isBranch;
    logic   brTaken;

    assign opc = opcodeT'(opcode);

    // shared funct3 decode for op and op-imm
    always_comb begin
        case (funct3)
            3'b000:  funcOp = (opc == OP_R && funct7b5) ? ALU_SUB : ALU_ADD;
            3'b001:  funcOp = ALU_SLL;
            3'b010:  funcOp = ALU_SLT;
            3'b011:  funcOp = ALU_SLTU;
            3'b100:  funcOp = ALU_XOR;
            3'b101:  funcOp = funct7b5 ? ALU_SRA : ALU_SRL;
            3'b110:  funcOp = ALU_OR;
            default: funcOp = ALU_AND;
        endcase
    end

    always_comb begin
        immType   = IMM_I;
        aluOp     = ALU_ADD;
        bSrc      = BSRC_REG;
        aSrcPc    = 1'b0;
        regWrite  = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        pcBaseRs1 = 1'b0;
        isBranch  = 1'b0;
        isHalt    = 1'b0;
        case (opc)
            OP_R: begin
                aluOp    = funcOp;
                regWrite = 1'b1;
            end
            OP_I: begin
                aluOp    = funcOp;
                bSrc     = BSRC_IMM;
                regWrite = 1'b1;
            end
            OP_LOAD: begin
                bSrc     = BSRC_IMM;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            OP_STORE: begin
                immType  = IMM_S;
                bSrc     = BSRC_IMM;
                memWrite = 1'b1;
            end
            OP_BRANCH: begin
                immType  = IMM_B;
                isBranch = 1'b1;
                // eq/ne compare by subtraction, the rest by set-less-than
                if (!funct3[2]) begin
                    aluOp = ALU_SUB;
                end else if (!funct3[1]) begin
                    aluOp = ALU_SLT;
                end else begin
                    aluOp = ALU_SLTU;
                end
            end
            OP_JAL, OP_JALR: begin
                // link value is pc + 4
                immType   = (opc == OP_JAL) ? IMM_J : IMM_I;
                aSrcPc    = 1'b1;
                bSrc      = BSRC_FOUR;
                regWrite  = 1'b1;
                pcBaseRs1 = (opc == OP_JALR);
            end
            OP_LUI: begin
                immType  = IMM_U;
                aluOp    = ALU_PASSB;
                bSrc     = BSRC_IMM;
                regWrite = 1'b1;
            end
            OP_AUIPC: begin
                immType  = IMM_U;
                aSrcPc   = 1'b1;
                bSrc     = BSRC_IMM;
                regWrite = 1'b1;
            end
            OP_SYSTEM: isHalt = (funct3 == 3'b000);
            // unknown opcodes fall through as no-ops
            default: ;
        endcase
    end

    // branch direction from funct3 and alu flags
    always_comb begin
        case (funct3)
            3'b000:  brTaken = zero;
            3'b001:  brTaken = !zero;
            3'b100:  brTaken = less;
            3'b101:  brTaken = !less;
            3'b110:  brTaken = less;
            3'b111:  brTaken = !less;
            default: brTaken = 1'b0;
        endcase
    end

    assign pcTaken = (opc == OP_JAL) || (opc == OP_JALR) || (isBranch && brTaken);

endmodule

/* flist.f */
rvPkg.sv
alu.sv
immGen.sv
controlUnit.sv
regFile.sv
wordMem.sv
rvCore.sv
tbChecker.sv
tbTop.sv

/* immGen.sv */
`timescale 1ns/1ps

module immGen (
    input  logic [31:0]    instr,
    input  rvPkg::immTypeT immType,
    output logic [31:0]    imm
);
    import rvPkg::*;

    always_comb begin
        case (immType)
            IMM_I: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            IMM_S: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // bit 0 is always zero for branches
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'h000};
            end
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  rdAddr,
    input  logic [31:0] rdData,
    input  logic        we,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rdAddr != 5'd0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? 32'd0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? 32'd0 : regs[rs2Addr];

    // a written register reads back its new value in the next cycle
    property writeReadBack;
        @(posedge clk) disable iff (!arstN)
            (we && rdAddr != 5'd0) |=>
                ((rs1Addr != $past(rdAddr) || rs1Data == $past(rdData)) &&
                 (rs2Addr != $past(rdAddr) || rs2Data == $past(rdData)));
    endproperty
    assert property (writeReadBack);

endmodule

/* run.sh */
#!/bin/sh
# compile and run the rvCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbTop -f flist.f -o simTop
./obj_dir/simTop | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* rvCore.sv */
`timescale 1ns/1ps

module rvCore (
    input  logic        clk,
    input  logic        arstN,
    input  logic        run,
    input  logic        loadEn,
    input  logic [7:0]  loadAddr,
    input  logic [31:0] loadData,
    output logic        retireValid,
    output logic [31:0] retirePc,
    output logic [4:0]  retireRd,
    output logic [31:0] retireData,
    output logic        halted
);
    import rvPkg::*;

    logic [XLEN-1:0]    pc;
    logic               running;
    logic               exec;
    logic [31:0]        instr;
    logic [IMEM_AW-1:0] imemAddr;
    logic [4:0]         rd;

    immTypeT immType;
    aluOpT   aluOp;
    bSrcT    bSrc;
    logic    aSrcPc, regWrite, memRead, memWrite, pcBaseRs1, pcTaken, isHalt;
    logic    zero, less;

    logic [XLEN-1:0] imm, rs1Data, rs2Data, aluA, aluB, aluResult;
    logic [XLEN-1:0] memRdata, wbData, target, nextPc;

    assign exec = running && !halted;
    assign rd   = instr[11:7];

    // load port owns imem while idle
    assign imemAddr = running ? pc[IMEM_AW+1:2] : loadAddr;

    wordMem #(.DEPTH(IMEM_WORDS)) imem (
        .clk(clk), .arstN(arstN), .we(loadEn && !run && !running),
        .addr(imemAddr), .wdata(loadData), .rdata(instr)
    );

    controlUnit ctrl (
        .opcode(instr[6:0]), .funct3(instr[14:12]), .funct7b5(instr[30]),
        .zero(zero), .less(less), .immType(immType), .aluOp(aluOp), .bSrc(bSrc),
        .aSrcPc(aSrcPc), .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .pcBaseRs1(pcBaseRs1), .pcTaken(pcTaken), .isHalt(isHalt)
    );

    immGen immUnit (.instr(instr), .immType(immType), .imm(imm));

    regFile regs (
        .clk(clk), .arstN(arstN), .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
        .rdAddr(rd), .rdData(wbData), .we(exec && regWrite),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    // operand selection
    assign aluA = aSrcPc ? pc : rs1Data;
    always_comb begin
        case (bSrc)
            BSRC_REG:  aluB = rs2Data;
            BSRC_IMM:  aluB = imm;
            BSRC_FOUR: aluB = 32'd4;
            default:   aluB = '0;
        endcase
    end

    alu aluUnit (
        .a(aluA), .b(aluB), .aluOp(aluOp), .result(aluResult), .zero(zero), .less(less)
    );

    wordMem #(.DEPTH(DMEM_WORDS)) dmem (
        .clk(clk), .arstN(arstN), .we(exec && memWrite),
        .addr(aluResult[DMEM_AW+1:2]), .wdata(rs2Data), .rdata(memRdata)
    );

    assign wbData = memRead ? memRdata : aluResult;

    // jalr clears bit 0 of its target
    assign target = pcBaseRs1 ? ((rs1Data + imm) & ~32'd1) : (pc + imm);
    assign nextPc = pcTaken ? target : (pc + 32'd4);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (!run) begin
            pc      <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
        end else if (!running) begin
            running <= 1'b1;
        end else if (!halted) begin
            pc <= nextPc;
            if (isHalt) begin
                halted <= 1'b1;
            end
        end
    end

    // retire trace, x0 writes report as no write
    assign retireValid = exec;
    assign retirePc    = pc;
    assign retireRd    = (regWrite && rd != 5'd0) ? rd : 5'd0;
    assign retireData  = (regWrite && rd != 5'd0) ? wbData : 32'd0;

    assert property (@(posedge clk) disable iff (!arstN) running |-> pc[1:0] == 2'b00);

endmodule

/* rvPkg.sv */
package rvPkg;

    // data and address width
    localparam int XLEN = 32;

    // memory depths in words
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 64;
    localparam int IMEM_AW = $clog2(IMEM_WORDS);
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    // rv32i major opcodes
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_SYSTEM = 7'b1110011
    } opcodeT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } aluOpT;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immTypeT;

    // operand b source
    typedef enum logic [1:0] {BSRC_REG, BSRC_IMM, BSRC_FOUR} bSrcT;

endpackage

/* tbChecker.sv */
`timescale 1ns/1ps

module tbChecker #(
    parameter int TRACE_MAX = 64
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        run,
    input  logic        retireValid,
    input  logic [31:0] retirePc,
    input  logic [4:0]  retireRd,
    input  logic [31:0] retireData,
    input  logic        halted,
    input  logic [31:0] expPc [TRACE_MAX],
    input  logic [4:0]  expRd [TRACE_MAX],
    input  logic [31:0] expData [TRACE_MAX],
    input  int          expLen,
    output int          errorCount,
    output int          checkCount,
    output int          retireCount
);

    int   idx;
    logic seenRun;
    logic haltSeen;
    logic haltDue;

    task automatic compareField(string name, logic [31:0] got, logic [31:0] want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("Fail at %0t ns: %s is %h, expected %h (trace entry %0d)",
                     $time, name, got, want, idx);
        end
    endtask

    // sampled mid-cycle, away from the edge and the input drive
    always @(negedge clk) begin
        if (!arstN) begin
            idx         = 0;
            seenRun     = 1'b0;
            haltSeen    = 1'b0;
            haltDue     = 1'b0;
            errorCount  = 0;
            checkCount  = 0;
            retireCount = 0;
        end else begin
            // ecall retired in the previous cycle
            if (haltDue && !halted) begin
                errorCount++;
                $display("halted did not rise after the last retirement at %0t ns", $time);
            end
            haltDue = 1'b0;
            if (!seenRun && (retireValid || halted)) begin
                errorCount++;
                $display("outputs active before the first run at %0t ns", $time);
            end
            if (!run && retireValid) begin
                errorCount++;
                $display("retirement at %0t ns while run is low", $time);
            end
            if (retireValid) begin
                retireCount++;
                if (haltSeen) begin
                    errorCount++;
                    $display("retirement at %0t ns after the core halted", $time);
                end else if (idx >= expLen) begin
                    errorCount++;
                    $display("retirement at %0t ns beyond the %0d expected entries",
                             $time, expLen);
                end else begin
                    compareField("retirePc", retirePc, expPc[idx]);
                    compareField("retireRd", {27'd0, retireRd}, {27'd0, expRd[idx]});
                    compareField("retireData", retireData, expData[idx]);
                    idx++;
                    haltDue = (idx == expLen);
                end
            end
            if (run && halted && !haltSeen) begin
                haltSeen = 1'b1;
                checkCount++;
                if (idx != expLen) begin
                    errorCount++;
                    $display("core halted after %0d retirements, expected %0d", idx, expLen);
                end
            end
            if (run) begin
                seenRun = 1'b1;
            end else begin
                idx      = 0;
                haltSeen = 1'b0;
            end
        end
    end

endmodule

/* tbTop.sv */
`timescale 1ns/1ps

module tbTop;
    import rvPkg::*;

    localparam int SEED = 87932;
    localparam int NUM_PROGS = 20;
    localparam int PROG_LEN = 40;
    localparam int PROG_WORDS = PROG_LEN + 1;
    localparam int TRACE_MAX = 64;
    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES = 3;
    localparam int GAP_CYCLES = 10;
    // load, run, hold and gap per program plus reset, doubled for margin
    localparam int TIMEOUT_CYCLES =
        2 * (NUM_PROGS * (PROG_LEN + PROG_WORDS + HOLD_CYCLES + GAP_CYCLES) + RESET_CYCLES);

    logic        clk, arstN, run, loadEn;
    logic [7:0]  loadAddr;
    logic [31:0] loadData;
    logic        retireValid, halted;
    logic [31:0] retirePc, retireData;
    logic [4:0]  retireRd;

    logic [31:0] rngState = SEED;
    logic [31:0] prog [PROG_WORDS];
    logic [31:0] mReg [32];
    logic [31:0] mMem [DMEM_WORDS];
    logic [31:0] expPc [TRACE_MAX];
    logic [4:0]  expRd [TRACE_MAX];
    logic [31:0] expData [TRACE_MAX];
    int          expLen;
    int          errorCount, checkCount, retireCount;
    int          cycleCount = 0;

    rvCore DUT (
        .clk(clk), .arstN(arstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .retireValid(retireValid), .retirePc(retirePc),
        .retireRd(retireRd), .retireData(retireData), .halted(halted)
    );

    tbChecker #(.TRACE_MAX(TRACE_MAX)) traceCheck (
        .clk(clk), .arstN(arstN), .run(run), .retireValid(retireValid),
        .retirePc(retirePc), .retireRd(retireRd), .retireData(retireData),
        .halted(halted), .expPc(expPc), .expRd(expRd), .expData(expData),
        .expLen(expLen), .errorCount(errorCount), .checkCount(checkCount),
        .retireCount(retireCount)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the core never finished", cycleCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // x0 to x7 only, so results get reused
    function automatic logic [4:0] pickReg();
        logic [31:0] r;
        r = nextRandom();
        return {2'b00, r[2:0]};
    endfunction

    // word index after idx, the ecall slot included
    function automatic int forwardTarget(int idx);
        logic [31:0] r;
        r = nextRandom();
        return idx + 1 + int'(r % (PROG_LEN - idx));
    endfunction

    function automatic logic [31:0] encR(logic f7b5, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd);
        return {1'b0, f7b5, 5'b00000, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] aluModel(logic [2:0] f3, logic alt, logic [31:0] a,
                                             logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $unsigned($signed(a) >>> b[4:0]);
                end else begin
                    return a >> b[4:0];
                end
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchModel(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic buildProgram();
        logic [31:0] r, off;
        logic [2:0]  f3;
        logic [11:0] imm12;
        int          kind;
        for (int i = 0; i < PROG_LEN; i++) begin
            r = nextRandom();
            kind = int'(r % 32'd10);
            f3 = r[10:8];
            case (kind)
                0, 1: begin
                    prog[i] = encR(r[11] && (f3 == 3'b000 || f3 == 3'b101),
                                   pickReg(), pickReg(), f3, pickReg());
                end
                2, 3: begin
                    // shifts take a 5-bit shamt, srai sets bit 30
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm12 = {1'b0, r[12] && f3 == 3'b101, 5'b00000, r[20:16]};
                    end else begin
                        imm12 = r[31:20];
                    end
                    prog[i] = encI(imm12, pickReg(), f3, pickReg(), OP_I);
                end
                4: prog[i] = {r[31:12], pickReg(), r[11] ? OP_LUI : OP_AUIPC};
                5, 6: begin
                    // a narrow window half the time so loads find stored words
                    r = nextRandom();
                    off = (r[11] ? (r % 32'd8) : (r % DMEM_WORDS)) * 4;
                    if (kind == 5) begin
                        prog[i] = encI(off[11:0], 5'd0, 3'b010, pickReg(), OP_LOAD);
                    end else begin
                        prog[i] = encS(off[11:0], pickReg(), 5'd0);
                    end
                end
                7: begin
                    f3 = {r[9], r[9] ? r[8] : 1'b0, r[10]};
                    off = (forwardTarget(i) - i) * 4;
                    prog[i] = encB(off[12:0], pickReg(), pickReg(), f3);
                end
                8: begin
                    off = (forwardTarget(i) - i) * 4;
                    prog[i] = encJ(off[20:0], pickReg());
                end
                default: begin
                    off = forwardTarget(i) * 4;
                    prog[i] = encI(off[11:0], 5'd0, 3'b000, pickReg(), OP_JALR);
                end
            endcase
        end
        prog[PROG_LEN] = 32'h00000073;
    endtask

    // ISA model, state carries over from program to program
    task automatic runModel();
        logic [31:0] pc, ins, a, b, res, nextPc, immI, immS, immB, immU, immJ, addr;
        logic [4:0]  rd;
        logic        writes, done;
        int          n;
        pc = '0;
        n = 0;
        done = 1'b0;
        while (!done && n < TRACE_MAX) begin
            ins  = prog[int'(pc >> 2)];
            rd   = ins[11:7];
            a    = mReg[int'(ins[19:15])];
            b    = mReg[int'(ins[24:20])];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immU = {ins[31:12], 12'h000};
            immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            writes = 1'b1;
            res = '0;
            nextPc = pc + 32'd4;
            case (ins[6:0])
                OP_R: res = aluModel(ins[14:12], ins[30], a, b);
                OP_I: res = aluModel(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, immI);
                OP_LUI: res = immU;
                OP_AUIPC: res = pc + immU;
                OP_LOAD: begin
                    addr = a + immI;
                    res = mMem[int'(addr[7:2])];
                end
                OP_STORE: begin
                    addr = a + immS;
                    mMem[int'(addr[7:2])] = b;
                    writes = 1'b0;
                end
                OP_BRANCH: begin
                    writes = 1'b0;
                    if (branchModel(ins[14:12], a, b)) begin
                        nextPc = pc + immB;
                    end
                end
                OP_JAL: begin
                    res = pc + 32'd4;
                    nextPc = pc + immJ;
                end
                OP_JALR: begin
                    res = pc + 32'd4;
                    nextPc = (a + immI) & ~32'd1;
                end
                OP_SYSTEM: begin
                    writes = 1'b0;
                    done = 1'b1;
                end
                default: writes = 1'b0;
            endcase
            expPc[n]   = pc;
            expRd[n]   = (writes && rd != 5'd0) ? rd : 5'd0;
            expData[n] = (writes && rd != 5'd0) ? res : 32'd0;
            if (writes && rd != 5'd0) begin
                mReg[int'(rd)] = res;
            end
            n++;
            pc = nextPc;
        end
        expLen = n;
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < PROG_WORDS; i++) begin
            loadEn   = 1'b1;
            loadAddr = i[7:0];
            loadData = prog[i];
            stepCycle();
        end
        loadEn = 1'b0;
    endtask

    task automatic runProgram();
        run = 1'b1;
        do begin
            stepCycle();
        end while (!halted);
        // run stays up past the halt so a late retirement would show
        repeat (HOLD_CYCLES) stepCycle();
        run = 1'b0;
        repeat (GAP_CYCLES) stepCycle();
    endtask

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        run      = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        expLen   = 0;
        for (int i = 0; i < 32; i++) begin
            mReg[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mMem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arstN = 1'b1;
        // a few idle cycles before the first program
        repeat (4) stepCycle();
        for (int p = 0; p < NUM_PROGS; p++) begin
            buildProgram();
            loadProgram();
            runModel();
            runProgram();
        end
        repeat (2) stepCycle();
        $display("checks %0d, retirements %0d, errors %0d", checkCount, retireCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* wordMem.sv */
`timescale 1ns/1ps

module wordMem #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [31:0]              wdata,
    output logic [31:0]              rdata
);

    logic [31:0] mem [DEPTH];

    // all words clear to zero on reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    // asynchronous read
    assign rdata = mem[addr];

endmodule
